// ==== logic/udp_tx_pkg.sv ====
package udp_tx_pkg;

	// ----------------------------------------
	// Frame layout
	// ----------------------------------------
	localparam int PREAMBLE_BYTES = 7;
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hd5;
	localparam int HDR_BYTES = 42;
	localparam int LNUM_BYTES = 2;
	localparam int FCS_BYTES = 4;
	localparam int IFG_CYCLES = 12;
	localparam int IP_HDR_BYTES = 20;
	localparam int UDP_HDR_BYTES = 8;

	// Fixed header fields
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0] IP_VER_IHL = 8'h45;
	localparam logic [7:0] IP_TOS = 8'h00;
	localparam logic [15:0] IP_IDENT = 16'h0000;
	localparam logic [15:0] IP_FLAGS = 16'h4000;
	localparam logic [7:0] IP_TTL = 8'h40;
	localparam logic [7:0] IP_PROTO_UDP = 8'h11;

	// Register values after reset
	localparam logic [47:0] DEF_DST_MAC = 48'h00_23_45_67_89_02;
	localparam logic [47:0] DEF_SRC_MAC = 48'h00_23_45_67_89_01;
	localparam logic [31:0] DEF_SRC_IP = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] DEF_DST_IP = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] DEF_SRC_PORT = 16'd12344;
	localparam logic [15:0] DEF_DST_PORT = 16'd12345;

	// ----------------------------------------
	// Configuration and pixel types
	// ----------------------------------------
	typedef enum logic [2:0] {
		DST_MAC_HI = 3'd0,
		DST_MAC_LO = 3'd1,
		SRC_MAC_HI = 3'd2,
		SRC_MAC_LO = 3'd3,
		SRC_IP     = 3'd4,
		DST_IP     = 3'd5,
		UDP_PORTS  = 3'd6,
		MODE       = 3'd7
	} cfg_addr_e;

	typedef enum logic {
		PIX_YUV = 1'b0,
		PIX_RGB = 1'b1
	} pix_mode_e;

	// One FIFO word, two readings
	typedef union packed {
		struct packed {
			logic [7:0] r;
			logic [7:0] g;
			logic [7:0] b;
		} rgb;
		struct packed {
			logic [7:0] y;
			logic [7:0] chroma;
			logic [7:0] unused;
		} yuv;
	} pixel_word_u;

endpackage

// ==== logic/hdr_if.sv ====
`timescale 1ns/1ps

interface hdr_if;
	logic [47:0]           dst_mac;
	logic [47:0]           src_mac;
	logic [31:0]           src_ip;
	logic [31:0]           dst_ip;
	logic [15:0]           src_port;
	logic [15:0]           dst_port;
	udp_tx_pkg::pix_mode_e mode;
	logic [15:0]           ip_total_len;
	logic [15:0]           udp_len;
	logic [15:0]           ip_csum;
	// Lengths and checksum match the registers
	logic                  hdr_valid;

	modport cfg (output dst_mac, src_mac, src_ip, dst_ip, src_port, dst_port, mode,
		ip_total_len, udp_len, ip_csum, hdr_valid);
	modport seq (input dst_mac, src_mac, src_ip, dst_ip, src_port, dst_port, mode,
		ip_total_len, udp_len, ip_csum, hdr_valid);
endinterface

// ==== logic/crc32_gen.sv ====
`timescale 1ns/1ps

module crc32_gen (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        crc_init,
	input  logic        crc_en,
	input  logic [7:0]  data,
	output logic [31:0] fcs
);

	// Reflected form of 0x04c11db7
	localparam logic [31:0] CRC_POLY = 32'hedb88320;

	logic [31:0] crc;

	// LSB of the byte goes in first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
		logic [31:0] c;
		c = crc_in;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ d[i]) begin
				c = (c >> 1) ^ CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc <= '1;
		end else if (crc_init) begin
			crc <= '1;
		end else if (crc_en) begin
			crc <= crc_byte(crc, data);
		end
	end

	// Sent low byte first
	assign fcs = ~crc;

endmodule

// ==== logic/frame_config.sv ====
`timescale 1ns/1ps

module frame_config #(
	parameter int LINE_PIXELS = 32
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        cfg_wr,
	input  logic [2:0]  cfg_addr,
	input  logic [31:0] cfg_data,
	hdr_if.cfg          hdr
);

	// Header words that never change, summed once
	localparam logic [19:0] CONST_SUM =
		20'({udp_tx_pkg::IP_VER_IHL, udp_tx_pkg::IP_TOS}) + 20'(udp_tx_pkg::IP_IDENT) +
		20'(udp_tx_pkg::IP_FLAGS) + 20'({udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTO_UDP});
	localparam logic [15:0] LEN_FIXED =
		16'(udp_tx_pkg::UDP_HDR_BYTES + udp_tx_pkg::LNUM_BYTES);

	logic [15:0]           dst_mac_hi;
	logic [31:0]           dst_mac_lo;
	logic [15:0]           src_mac_hi;
	logic [31:0]           src_mac_lo;
	logic [31:0]           src_ip;
	logic [31:0]           dst_ip;
	logic [31:0]           udp_ports;
	udp_tx_pkg::pix_mode_e mode;

	logic [2:0]  calc_step;
	logic [19:0] csum_acc;
	logic [15:0] udp_len;
	logic [15:0] ip_total_len;
	logic [15:0] ip_csum;
	logic        hdr_valid;
	logic [15:0] line_bytes;

	// End-around carry, twice is enough for a 20-bit sum
	function automatic logic [15:0] fold_sum(input logic [19:0] acc);
		logic [16:0] part;
		part = {1'b0, acc[15:0]} + {13'd0, acc[19:16]};
		return part[15:0] + {15'd0, part[16]};
	endfunction

	assign line_bytes = (mode == udp_tx_pkg::PIX_RGB) ? 16'(3 * LINE_PIXELS) :
		16'(2 * LINE_PIXELS);

	// ----------------------------------------
	// Registers and step control
	// ----------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			dst_mac_hi <= udp_tx_pkg::DEF_DST_MAC[47:32];
			dst_mac_lo <= udp_tx_pkg::DEF_DST_MAC[31:0];
			src_mac_hi <= udp_tx_pkg::DEF_SRC_MAC[47:32];
			src_mac_lo <= udp_tx_pkg::DEF_SRC_MAC[31:0];
			src_ip <= udp_tx_pkg::DEF_SRC_IP;
			dst_ip <= udp_tx_pkg::DEF_DST_IP;
			udp_ports <= {udp_tx_pkg::DEF_SRC_PORT, udp_tx_pkg::DEF_DST_PORT};
			mode <= udp_tx_pkg::PIX_YUV;
			calc_step <= 3'd1;
			hdr_valid <= 1'b0;
		end else if (cfg_wr) begin
			case (udp_tx_pkg::cfg_addr_e'(cfg_addr))
				udp_tx_pkg::DST_MAC_HI: dst_mac_hi <= cfg_data[15:0];
				udp_tx_pkg::DST_MAC_LO: dst_mac_lo <= cfg_data;
				udp_tx_pkg::SRC_MAC_HI: src_mac_hi <= cfg_data[15:0];
				udp_tx_pkg::SRC_MAC_LO: src_mac_lo <= cfg_data;
				udp_tx_pkg::SRC_IP: src_ip <= cfg_data;
				udp_tx_pkg::DST_IP: dst_ip <= cfg_data;
				udp_tx_pkg::UDP_PORTS: udp_ports <= cfg_data;
				default: mode <= udp_tx_pkg::pix_mode_e'(cfg_data[0]);
			endcase
			// Restart the sum on every write
			calc_step <= 3'd1;
			hdr_valid <= 1'b0;
		end else if (calc_step == 3'd6) begin
			calc_step <= 3'd0;
			hdr_valid <= 1'b1;
		end else if (calc_step != 3'd0) begin
			calc_step <= calc_step + 3'd1;
		end
	end

	// One header word per step
	always_ff @(posedge fifo_clk) begin
		case (calc_step)
			3'd1: begin
				udp_len <= LEN_FIXED + line_bytes;
				csum_acc <= CONST_SUM + {4'd0, src_ip[31:16]};
			end
			3'd2: begin
				ip_total_len <= udp_len + 16'(udp_tx_pkg::IP_HDR_BYTES);
				csum_acc <= csum_acc + {4'd0, src_ip[15:0]};
			end
			3'd3: csum_acc <= csum_acc + {4'd0, dst_ip[31:16]};
			3'd4: csum_acc <= csum_acc + {4'd0, dst_ip[15:0]};
			3'd5: csum_acc <= csum_acc + {4'd0, ip_total_len};
			3'd6: ip_csum <= ~fold_sum(csum_acc);
			default: csum_acc <= csum_acc;
		endcase
	end

	assign hdr.dst_mac = {dst_mac_hi, dst_mac_lo};
	assign hdr.src_mac = {src_mac_hi, src_mac_lo};
	assign hdr.src_ip = src_ip;
	assign hdr.dst_ip = dst_ip;
	assign hdr.src_port = udp_ports[31:16];
	assign hdr.dst_port = udp_ports[15:0];
	assign hdr.mode = mode;
	assign hdr.ip_total_len = ip_total_len;
	assign hdr.udp_len = udp_len;
	assign hdr.ip_csum = ip_csum;
	assign hdr.hdr_valid = hdr_valid;

	// Only bit 0 carries the mode
	mode_write_legal: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(cfg_wr && cfg_addr == udp_tx_pkg::MODE) |-> cfg_data[31:1] == '0)
		else $error("frame_config: illegal pixel mode write %h", cfg_data);

endmodule

// ==== logic/frame_tx_fsm.sv ====
`timescale 1ns/1ps

module frame_tx_fsm #(
	parameter int LINE_PIXELS = 32
) (
	input  logic                    fifo_clk,
	input  logic                    sys_rst,
	input  logic                    tx_enable,
	input  logic                    line_ready,
	input  logic                    pix_empty,
	input  udp_tx_pkg::pixel_word_u pix_data,
	output logic                    pix_rd,
	hdr_if.seq                      hdr,
	output logic                    tx_en,
	output logic [7:0]              txd
);

	localparam logic [2:0] IDLE     = 3'd0;
	localparam logic [2:0] PREAMBLE = 3'd1;
	localparam logic [2:0] HEADER   = 3'd2;
	localparam logic [2:0] LINE_NUM = 3'd3;
	localparam logic [2:0] PAYLOAD  = 3'd4;
	localparam logic [2:0] FCS      = 3'd5;
	localparam logic [2:0] GAP      = 3'd6;

	localparam int PIX_W = $clog2(LINE_PIXELS + 1);
	localparam int HDR_BITS = 8 * udp_tx_pkg::HDR_BYTES;

	logic [2:0]            state;
	logic [5:0]            byte_cnt;
	logic [PIX_W-1:0]      pix_cnt;
	logic [1:0]            sub_cnt;
	logic [15:0]           line_num;
	logic [HDR_BITS-1:0]   hdr_latch;
	udp_tx_pkg::pix_mode_e mode_q;

	logic        start;
	logic        in_frame;
	logic        last_sub;
	logic        last_pix;
	logic [7:0]  pix_byte;
	logic [7:0]  tx_byte;
	logic        crc_init;
	logic        crc_en;
	logic [31:0] fcs;

	assign start = (state == IDLE) && tx_enable && line_ready && hdr.hdr_valid;
	assign in_frame = (state != IDLE) && (state != GAP);

	// Last byte of the pixel pops the FIFO
	assign last_sub = (mode_q == udp_tx_pkg::PIX_RGB) ? (sub_cnt == 2'd2) : (sub_cnt == 2'd1);
	assign last_pix = pix_cnt == PIX_W'(LINE_PIXELS - 1);
	assign pix_rd = (state == PAYLOAD) && last_sub;

	// CRC starts after the SFD
	assign crc_init = (state == PREAMBLE) && (byte_cnt == 6'(udp_tx_pkg::PREAMBLE_BYTES));
	assign crc_en = (state == HEADER) || (state == LINE_NUM) || (state == PAYLOAD);

	crc32_gen i_crc32_gen (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.crc_init (crc_init),
		.crc_en   (crc_en),
		.data     (tx_byte),
		.fcs      (fcs)
	);

	// ----------------------------------------
	// Byte selection
	// ----------------------------------------
	always_comb begin
		if (mode_q == udp_tx_pkg::PIX_RGB) begin
			case (sub_cnt)
				2'd0: pix_byte = pix_data.rgb.r;
				2'd1: pix_byte = pix_data.rgb.g;
				default: pix_byte = pix_data.rgb.b;
			endcase
		end else begin
			// Y, then the shared chroma byte
			pix_byte = (sub_cnt == 2'd0) ? pix_data.yuv.y : pix_data.yuv.chroma;
		end
	end

	always_comb begin
		case (state)
			PREAMBLE: tx_byte = (byte_cnt == 6'(udp_tx_pkg::PREAMBLE_BYTES)) ?
				udp_tx_pkg::SFD_BYTE : udp_tx_pkg::PREAMBLE_BYTE;
			HEADER: tx_byte = hdr_latch[8 * (udp_tx_pkg::HDR_BYTES - 1 - int'(byte_cnt)) +: 8];
			LINE_NUM: tx_byte = (byte_cnt == 6'd0) ? line_num[15:8] : line_num[7:0];
			PAYLOAD: tx_byte = pix_byte;
			FCS: tx_byte = fcs[8 * byte_cnt[1:0] +: 8];
			default: tx_byte = 8'h00;
		endcase
	end

	// Header fields held for the whole frame
	always_ff @(posedge fifo_clk) begin
		if (start) begin
			hdr_latch <= {hdr.dst_mac, hdr.src_mac, udp_tx_pkg::ETH_TYPE_IPV4,
				udp_tx_pkg::IP_VER_IHL, udp_tx_pkg::IP_TOS, hdr.ip_total_len,
				udp_tx_pkg::IP_IDENT, udp_tx_pkg::IP_FLAGS,
				udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTO_UDP, hdr.ip_csum,
				hdr.src_ip, hdr.dst_ip,
				hdr.src_port, hdr.dst_port, hdr.udp_len, 16'h0000};
			mode_q <= hdr.mode;
		end
	end

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			byte_cnt <= 6'd0;
			pix_cnt <= '0;
			sub_cnt <= 2'd0;
			line_num <= 16'd0;
			tx_en <= 1'b0;
			txd <= 8'h00;
		end else begin
			tx_en <= in_frame;
			txd <= tx_byte;
			case (state)
				IDLE: begin
					byte_cnt <= 6'd0;
					if (start) begin
						state <= PREAMBLE;
					end
				end
				PREAMBLE: begin
					byte_cnt <= byte_cnt + 6'd1;
					if (byte_cnt == 6'(udp_tx_pkg::PREAMBLE_BYTES)) begin
						state <= HEADER;
						byte_cnt <= 6'd0;
					end
				end
				HEADER: begin
					byte_cnt <= byte_cnt + 6'd1;
					if (byte_cnt == 6'(udp_tx_pkg::HDR_BYTES - 1)) begin
						state <= LINE_NUM;
						byte_cnt <= 6'd0;
					end
				end
				LINE_NUM: begin
					byte_cnt <= byte_cnt + 6'd1;
					if (byte_cnt == 6'(udp_tx_pkg::LNUM_BYTES - 1)) begin
						state <= PAYLOAD;
						byte_cnt <= 6'd0;
						pix_cnt <= '0;
						sub_cnt <= 2'd0;
					end
				end
				PAYLOAD: begin
					if (!last_sub) begin
						sub_cnt <= sub_cnt + 2'd1;
					end else if (last_pix) begin
						state <= FCS;
						sub_cnt <= 2'd0;
					end else begin
						sub_cnt <= 2'd0;
						pix_cnt <= pix_cnt + 1'b1;
					end
				end
				FCS: begin
					byte_cnt <= byte_cnt + 6'd1;
					if (byte_cnt == 6'(udp_tx_pkg::FCS_BYTES - 1)) begin
						state <= GAP;
						byte_cnt <= 6'd0;
					end
				end
				GAP: begin
					byte_cnt <= byte_cnt + 6'd1;
					if (byte_cnt == 6'(udp_tx_pkg::IFG_CYCLES - 1)) begin
						state <= IDLE;
						line_num <= line_num + 16'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// tx_en only changes at frame start and after the last FCS byte
	tx_en_in_frame: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(tx_en != in_frame) |-> ((state == GAP || state == PREAMBLE) && byte_cnt == 6'd0))
		else $error("frame_tx_fsm: tx_en dropped inside a frame");

	no_read_when_empty: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		pix_rd |-> !pix_empty)
		else $error("frame_tx_fsm: pixel read from an empty FIFO");

endmodule

// ==== logic/gmii_udp_tx.sv ====
`timescale 1ns/1ps

module gmii_udp_tx #(
	parameter int LINE_PIXELS = 32
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        tx_enable,
	input  logic        line_ready,
	input  logic        pix_empty,
	input  logic [23:0] pix_data,
	output logic        pix_rd,
	input  logic        cfg_wr,
	input  logic [2:0]  cfg_addr,
	input  logic [31:0] cfg_data,
	output logic        tx_en,
	output logic [7:0]  txd
);

	// Header settings from the register block to the sequencer
	hdr_if hdr_bus ();

	frame_config #(
		.LINE_PIXELS (LINE_PIXELS)
	) i_frame_config (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.hdr      (hdr_bus.cfg)
	);

	frame_tx_fsm #(
		.LINE_PIXELS (LINE_PIXELS)
	) i_frame_tx_fsm (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.tx_enable  (tx_enable),
		.line_ready (line_ready),
		.pix_empty  (pix_empty),
		.pix_data   (pix_data),
		.pix_rd     (pix_rd),
		.hdr        (hdr_bus.seq),
		.tx_en      (tx_en),
		.txd        (txd)
	);

endmodule

// ==== include/frame_ref.svh ====
`ifndef FRAME_REF_SVH
`define FRAME_REF_SVH

typedef logic [7:0]  byte_q_t[$];
typedef logic [23:0] pix_q_t[$];

typedef struct packed {
	logic [47:0] dst_mac;
	logic [47:0] src_mac;
	logic [31:0] src_ip;
	logic [31:0] dst_ip;
	logic [15:0] src_port;
	logic [15:0] dst_port;
	logic        rgb;
} frame_cfg_t;

// Append n bytes, most significant first
function automatic void push_be(ref byte_q_t q, input logic [47:0] v, input int n);
	for (int i = n - 1; i >= 0; i--) begin
		q.push_back(v[8 * i +: 8]);
	end
endfunction

// IPv4 header checksum with the checksum field as zero
function automatic logic [15:0] ip_checksum(input frame_cfg_t cfg, input logic [15:0] ip_len);
	logic [31:0] sum;
	sum = 32'h4500 + 32'(ip_len) + 32'h0000 + 32'h4000 + 32'h4011;
	sum = sum + 32'(cfg.src_ip[31:16]) + 32'(cfg.src_ip[15:0]);
	sum = sum + 32'(cfg.dst_ip[31:16]) + 32'(cfg.dst_ip[15:0]);
	while (sum[31:16] != 16'd0) begin
		sum = 32'(sum[15:0]) + 32'(sum[31:16]);
	end
	return ~sum[15:0];
endfunction

// Ethernet FCS, bitwise over the reflected polynomial
function automatic logic [31:0] crc32(input byte_q_t data);
	logic [31:0] crc;
	crc = 32'hffffffff;
	foreach (data[i]) begin
		crc = crc ^ {24'd0, data[i]};
		for (int b = 0; b < 8; b++) begin
			crc = crc[0] ? ((crc >> 1) ^ 32'hedb88320) : (crc >> 1);
		end
	end
	return ~crc;
endfunction

function automatic void build_frame(input frame_cfg_t cfg, input logic [15:0] lnum,
	input pix_q_t pix, output byte_q_t frame);
	byte_q_t     body;
	logic [15:0] udp_len;
	logic [15:0] ip_len;
	logic [31:0] fcs;
	udp_len = 16'(10 + (cfg.rgb ? 3 : 2) * pix.size());
	ip_len = udp_len + 16'd20;
	body = {};
	push_be(body, cfg.dst_mac, 6);
	push_be(body, cfg.src_mac, 6);
	push_be(body, 48'h0800, 2);
	push_be(body, 48'h4500, 2);
	push_be(body, 48'(ip_len), 2);
	// Identification, then flags with DF set
	push_be(body, 48'h0000_4000, 4);
	push_be(body, 48'h4011, 2);
	push_be(body, 48'(ip_checksum(cfg, ip_len)), 2);
	push_be(body, 48'(cfg.src_ip), 4);
	push_be(body, 48'(cfg.dst_ip), 4);
	push_be(body, 48'({cfg.src_port, cfg.dst_port}), 4);
	push_be(body, 48'({udp_len, 16'h0000}), 4);
	push_be(body, 48'(lnum), 2);
	foreach (pix[i]) begin
		body.push_back(pix[i][23:16]);
		body.push_back(pix[i][15:8]);
		if (cfg.rgb) begin
			body.push_back(pix[i][7:0]);
		end
	end
	fcs = crc32(body);
	frame = {};
	repeat (7) frame.push_back(8'h55);
	frame.push_back(8'hd5);
	foreach (body[i]) begin
		frame.push_back(body[i]);
	end
	for (int i = 0; i < 4; i++) begin
		frame.push_back(fcs[8 * i +: 8]);
	end
endfunction

`endif

// ==== bench/gmii_udp_tx_tb.sv ====
`timescale 1ns/1ps

module gmii_udp_tx_tb;

	localparam int LINE_PIXELS = 16;
	localparam int IFG = 12;
	localparam int FRAME_MAX = 8 + 42 + 2 + 3 * LINE_PIXELS + 4;
	localparam int CYCLE_LIMIT = 8 * (FRAME_MAX + IFG) + 200;

	`include "frame_ref.svh"

	logic        fifo_clk = 1'b0;
	logic        sys_rst;
	logic        tx_enable;
	logic        line_ready;
	logic        pix_empty;
	logic [23:0] pix_data;
	logic        pix_rd;
	logic        cfg_wr;
	logic [2:0]  cfg_addr;
	logic [31:0] cfg_data;
	logic        tx_en;
	logic [7:0]  txd;

	pix_q_t      fifo_q;
	// Pixels pushed but not yet matched to a frame
	pix_q_t      sent_q;
	byte_q_t     cap_q;
	frame_cfg_t  cfg;
	frame_cfg_t  frame_cfg;
	logic        pop_req = 1'b0;
	logic        tx_en_d = 1'b0;
	logic [15:0] line_cnt = 16'd0;
	int          frame_pops = 0;
	int          stray_pops = 0;
	int          frames_done = 0;
	int          tx_cycles = 0;
	int          gap_len = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          cycles = 0;

	always #50 fifo_clk = ~fifo_clk;

	gmii_udp_tx #(
		.LINE_PIXELS (LINE_PIXELS)
	) i_dut (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.tx_enable  (tx_enable),
		.line_ready (line_ready),
		.pix_empty  (pix_empty),
		.pix_data   (pix_data),
		.pix_rd     (pix_rd),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.tx_en      (tx_en),
		.txd        (txd)
	);

	// ----------------------------------------
	// FWFT pixel FIFO model
	// ----------------------------------------
	always @(posedge fifo_clk) begin
		#1;
		if (pop_req && fifo_q.size() > 0) begin
			void'(fifo_q.pop_front());
		end
		#1;
		pix_empty = fifo_q.size() == 0;
		pix_data = (fifo_q.size() > 0) ? fifo_q[0] : 24'h000000;
		line_ready = fifo_q.size() >= LINE_PIXELS;
	end

	always @(posedge fifo_clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	task automatic check_frame();
		pix_q_t  pix;
		byte_q_t exp_q;
		int      n;
		assert (sent_q.size() >= LINE_PIXELS) else begin
			$display("A frame was sent with fewer than %0d pixels queued", LINE_PIXELS);
			errors++;
		end
		while (pix.size() < LINE_PIXELS && sent_q.size() > 0) begin
			pix.push_back(sent_q.pop_front());
		end
		build_frame(frame_cfg, line_cnt, pix, exp_q);
		assert (cap_q.size() == exp_q.size()) else begin
			$display("FAIL %0t: frame %0d has %0d bytes, expected %0d", $time, line_cnt,
				cap_q.size(), exp_q.size());
			errors++;
		end
		n = (cap_q.size() < exp_q.size()) ? cap_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			assert (cap_q[i] == exp_q[i]) else begin
				$display("FAIL %0t: frame %0d byte %0d is %h, expected %h", $time, line_cnt,
					i, cap_q[i], exp_q[i]);
				errors++;
			end
		end
		assert (frame_pops == LINE_PIXELS) else begin
			$display("FAIL %0t: frame %0d popped %0d pixels, expected %0d", $time, line_cnt,
				frame_pops, LINE_PIXELS);
			errors++;
		end
		line_cnt++;
		frames_done++;
	endtask

	// Capture, sampled mid-cycle
	always @(negedge fifo_clk) begin
		if (!sys_rst) begin
			pop_req = pix_rd;
			if (pix_rd) begin
				assert (fifo_q.size() > 0) else begin
					$display("The DUT read a pixel from an empty FIFO at %0t", $time);
					errors++;
				end
				if (tx_en) begin
					frame_pops++;
				end else begin
					stray_pops++;
				end
			end
			if (tx_en) begin
				tx_cycles++;
				if (!tx_en_d) begin
					assert (frames_done == 0 || gap_len >= IFG) else begin
						$display("FAIL %0t: gap of %0d cycles before frame", $time, gap_len);
						errors++;
					end
					frame_cfg = cfg;
					cap_q = {};
					frame_pops = 0;
				end
				cap_q.push_back(txd);
			end else begin
				if (tx_en_d) begin
					check_frame();
					gap_len = 0;
				end
				gap_len++;
			end
			tx_en_d = tx_en;
		end
	end

	task automatic tick();
		@(posedge fifo_clk);
		#1;
	endtask

	task automatic push_pixels(input int n);
		udp_tx_pkg::pixel_word_u px;
		for (int i = 0; i < n; i++) begin
			if (cfg.rgb) begin
				px.rgb.r = 8'($urandom);
				px.rgb.g = 8'($urandom);
				px.rgb.b = 8'($urandom);
			end else begin
				px.yuv.y = 8'($urandom);
				px.yuv.chroma = 8'($urandom);
				px.yuv.unused = 8'($urandom);
			end
			fifo_q.push_back(px);
			sent_q.push_back(px);
		end
	endtask

	task automatic write_cfg(input logic [2:0] addr, input logic [31:0] data);
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_data = data;
		tick();
		cfg_wr = 1'b0;
	endtask

	task automatic wait_frames(input int target);
		while (frames_done < target) begin
			tick();
		end
	endtask

	task automatic report_test(input string name, input int err_mark);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_mark);
		end
	endtask

	task automatic expect_idle(input int tx_mark);
		assert (tx_cycles == tx_mark && stray_pops == 0) else begin
			$display("A frame started or a pixel was read while start was not allowed");
			errors++;
		end
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		int err_mark;
		int tx_mark;
		void'($urandom(82));
		sys_rst = 1'b1;
		tx_enable = 1'b0;
		line_ready = 1'b0;
		pix_empty = 1'b1;
		pix_data = 24'h000000;
		cfg_wr = 1'b0;
		cfg_addr = 3'd0;
		cfg_data = 32'd0;
		cfg = '{udp_tx_pkg::DEF_DST_MAC, udp_tx_pkg::DEF_SRC_MAC, udp_tx_pkg::DEF_SRC_IP,
			udp_tx_pkg::DEF_DST_IP, udp_tx_pkg::DEF_SRC_PORT, udp_tx_pkg::DEF_DST_PORT, 1'b0};
		repeat (10) @(posedge fifo_clk);
		#1;
		sys_rst = 1'b0;

		err_mark = errors;
		tx_enable = 1'b1;
		repeat (40) tick();
		expect_idle(0);
		report_test("idle_after_reset", err_mark);

		err_mark = errors;
		push_pixels(LINE_PIXELS);
		wait_frames(1);
		report_test("yuv_default", err_mark);

		// Line numbers 1 to 3
		err_mark = errors;
		push_pixels(3 * LINE_PIXELS);
		wait_frames(4);
		report_test("back_to_back", err_mark);

		err_mark = errors;
		cfg = '{48'h02_0a_0b_0c_0d_0e, 48'h02_11_22_33_44_55, 32'h0a00_0007, 32'h0a00_0063,
			16'd5004, 16'd5005, 1'b1};
		write_cfg(3'd0, 32'(cfg.dst_mac[47:32]));
		write_cfg(3'd1, cfg.dst_mac[31:0]);
		write_cfg(3'd2, 32'(cfg.src_mac[47:32]));
		write_cfg(3'd3, cfg.src_mac[31:0]);
		write_cfg(3'd4, cfg.src_ip);
		write_cfg(3'd5, cfg.dst_ip);
		write_cfg(3'd6, {cfg.src_port, cfg.dst_port});
		write_cfg(3'd7, 32'd1);
		repeat (8) tick();
		push_pixels(LINE_PIXELS);
		wait_frames(5);
		report_test("rgb_reconfig", err_mark);

		err_mark = errors;
		repeat (IFG + 4) tick();
		tx_mark = tx_cycles;
		tx_enable = 1'b0;
		push_pixels(LINE_PIXELS - 6);
		repeat (30) tick();
		expect_idle(tx_mark);
		tx_enable = 1'b1;
		repeat (30) tick();
		expect_idle(tx_mark);
		tx_enable = 1'b0;
		push_pixels(6);
		repeat (30) tick();
		expect_idle(tx_mark);
		tx_enable = 1'b1;
		wait_frames(6);
		repeat (4) tick();
		assert (fifo_q.size() == 0 && stray_pops == 0) else begin
			$display("Pixels left in the FIFO or read outside a frame");
			errors++;
		end
		report_test("start_conditions", err_mark);

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== gmii_udp_tx.f ====
+incdir+include
logic/udp_tx_pkg.sv
logic/hdr_if.sv
logic/crc32_gen.sv
logic/frame_config.sv
logic/frame_tx_fsm.sv
logic/gmii_udp_tx.sv
bench/gmii_udp_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f gmii_udp_tx.f --top-module gmii_udp_tx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vgmii_udp_tx_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1
